// File: runner_core.f
design/runner_pkg.sv
design/runner_ifs.sv
design/button_conditioner.sv
design/frame_sequencer.sv
design/player_physics.sv
design/hex_display_scanner.sv
design/runner_core.sv
testbench/tb_clock_gen.sv
testbench/runner_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the runner_core testbench with Verilator

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module runner_core_tb \
    -f runner_core.f -o runner_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/runner_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// File: testbench/runner_patterns.txt
// frames btn lag | obs_valid lane kind depth | exp lane height score ducking game_over
// btn bits: 8 left, 4 duck, 2 jump, 1 right; all values hex
1   1 00  0 0 0 000  1 ff80 0002 0 0
1   1 00  0 0 0 000  2 ff80 0003 0 0
1   1 00  0 0 0 000  2 ff80 0004 0 0
1   0 64  0 0 0 000  2 ff80 0005 0 0
1   1 64  0 0 0 000  2 ff80 0006 0 0
1   0 64  0 0 0 000  2 ff80 0007 0 0
1   8 00  0 0 0 000  2 ff80 0008 0 0
1   0 00  0 0 0 000  1 ff80 0009 0 0
1   8 00  0 0 0 000  1 ff80 000a 0 0
1   0 00  0 0 0 000  0 ff80 000b 0 0
1   8 00  0 0 0 000  0 ff80 000c 0 0
1   0 00  0 0 0 000  0 ff80 000d 0 0
1   2 00  0 0 0 000  0 ff80 000e 0 0
1   0 00  0 0 0 000  0 003e 000f 0 0
1   2 00  0 0 0 000  0 00fb 0010 0 0
1   0 00  1 0 0 00a  0 01b7 0011 0 0
17b 0 00  1 1 2 005  0 ff80 018c 0 0
1   4 00  1 0 2 040  0 ff80 018d 0 0
1   0 00  0 0 0 000  0 ff80 018e 1 0
1   0 00  1 0 1 020  0 ff80 018f 1 0
7e  0 00  0 0 0 000  0 ff80 020d 1 0
1   0 00  0 0 0 000  0 ff80 020e 0 0
1   0 00  1 0 0 010  0 ff80 020e 0 1
2   1 00  1 0 2 008  0 ff80 020e 0 1

// File: testbench/runner_core_tb.sv
`timescale 1ns/100ps

module runner_core_tb;
    import runner_pkg::*;

    localparam int NUM_ROWS     = 24;
    localparam int ROW_WORDS    = 12;   // words per pattern row
    localparam int TICK_TIMEOUT = 1000; // cycles allowed between ticks
    localparam int MIN_FRAME    = 102;  // start + 100 settle + 1 lag
    localparam int LAG_STEP     = 2;    // matches LAG_SCALE below

    // active high hex font in gfedcba order
    localparam logic [6:0] FONT [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic           clk_render;
    logic           rst;
    logic [3:0]     btn;
    logic [7:0]     frame_lag;
    logic           obstacle_valid;
    logic [1:0]     obstacle_lane;
    obstacle_kind_t obstacle_kind;
    logic [10:0]    obstacle_depth;
    logic           frame_tick;
    logic           game_over;
    logic [1:0]     player_lane;
    logic [15:0]    player_height;
    logic [15:0]    player_score;
    logic           ducking;
    logic [7:0]     seg_an;
    logic [6:0]     seg_cat;

    logic [15:0] patterns [NUM_ROWS*ROW_WORDS];
    logic [31:0] rng;
    logic [15:0] last_score;    // last checked values shown on the display
    logic [15:0] last_height;
    int          errors   = 0;
    int          timeouts = 0;
    int          checks   = 0;

    // tick spacing monitor state
    int cyc       = 0;
    int last_tick = 0;
    int gap_exp   = MIN_FRAME;
    bit seen_tick = 0;

    tb_clock_gen #(.PERIOD(20.0)) u_clock (.clk_render(clk_render));

    runner_core #(
        .DEBOUNCE_CYCLES(4),
        .LAG_SCALE      (2),
        .DIGIT_CYCLES   (8)
    ) DUT (.*);

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic end_run;
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // sampled at the falling edge where outputs are stable
    task automatic wait_tick(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < TICK_TIMEOUT) begin
            @(negedge clk_render);
            n++;
            if (frame_tick) ok = 1'b1;
        end
    endtask

    // tick and then one cycle for the player update
    task automatic next_frame(output bit ok);
        wait_tick(ok);
        if (!ok) begin
            timeouts++;
            $display("timeout: no frame_tick within %0d cycles", TICK_TIMEOUT);
        end else begin
            @(negedge clk_render);
        end
    endtask

    task automatic check_player(input logic [1:0] lane, input logic [15:0] height,
                                input logic [15:0] score, input logic duck,
                                input logic over);
        check_value("player_lane", player_lane, lane);
        check_value("player_height", player_height, height);
        check_value("player_score", player_score, score);
        check_value("ducking", ducking, duck);
        check_value("game_over", game_over, over);
        last_score  = score;
        last_height = height;
    endtask

    // one valid pulse somewhere inside the frame
    task automatic inject_obstacle(input int base);
        rng = xorshift(rng);
        repeat (5 + rng[4:0]) @(posedge clk_render);
        obstacle_valid <= 1'b1;
        obstacle_lane  <= patterns[base+4][1:0];
        obstacle_kind  <= obstacle_kind_t'(patterns[base+5][1:0]);
        obstacle_depth <= patterns[base+6][10:0];
        @(posedge clk_render);
        obstacle_valid <= 1'b0;
    endtask

    task automatic check_display;
        logic [31:0] shown;
        logic [6:0]  cat_exp;
        logic [7:0]  seen;      // digits lit during the scan
        int          idx;
        shown = {last_score, last_height};
        seen  = '0;
        repeat (2 * 8 * 8) @(negedge clk_render);   // two full scans refresh the snapshot
        for (int n = 0; n < 8 * 8; n++) begin
            @(negedge clk_render);
            idx = -1;
            for (int i = 0; i < 8; i++) begin
                if (seg_an == ~(8'd1 << i)) idx = i;
            end
            check_value("seg_an one-hot low", 32'(idx >= 0), 32'd1);
            if (idx >= 0) begin
                seen[idx] = 1'b1;
                cat_exp   = ~FONT[shown[idx*4 +: 4]];
                check_value("seg_cat", seg_cat, cat_exp);
            end
        end
        check_value("digits scanned", seen, 8'hff);
    endtask

    // frame spacing follows the lag seen at the previous tick
    always @(negedge clk_render) begin
        cyc = cyc + 1;
        if (frame_tick) begin
            if (seen_tick) check_value("frame spacing", cyc - last_tick, gap_exp);
            seen_tick = 1'b1;
            last_tick = cyc;
            gap_exp   = (int'(frame_lag) * LAG_STEP > MIN_FRAME) ?
                        int'(frame_lag) * LAG_STEP : MIN_FRAME;
        end
    end

    initial begin
        int base;
        bit ok;
        rst            = 1'b1;
        btn            = 4'd0;
        frame_lag      = 8'd0;
        obstacle_valid = 1'b0;
        obstacle_lane  = 2'd0;
        obstacle_kind  = KIND_LOW_BARRIER;
        obstacle_depth = 11'd0;
        rng            = 32'd79;
        $readmemh("testbench/runner_patterns.txt", patterns);

        repeat (2) @(posedge clk_render);
        rst <= 1'b0;
        @(negedge clk_render);
        check_value("frame_tick", frame_tick, 1'b0);
        check_value("seg_an", seg_an, 8'hfe);               // digit 0 lit first
        check_player(2'd1, 16'hff80, 16'd0, 1'b0, 1'b0);   // reset values

        next_frame(ok);
        if (ok) begin
            check_player(2'd1, 16'hff80, 16'd1, 1'b0, 1'b0);   // first tick scores
        end

        for (int r = 0; r < NUM_ROWS && ok; r++) begin
            base = r * ROW_WORDS;
            @(posedge clk_render);
            btn       <= patterns[base+1][3:0];
            frame_lag <= patterns[base+2][7:0];
            if (patterns[base+3][0]) inject_obstacle(base);
            for (int k = 0; k < int'(patterns[base]) && ok; k++) begin
                next_frame(ok);
            end
            if (ok) begin
                check_player(patterns[base+7][1:0], patterns[base+8], patterns[base+9],
                             patterns[base+10][0], patterns[base+11][0]);
            end
        end

        if (ok) begin
            check_display();
        end
        end_run();
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real PERIOD = 20.0    // ns
) (
    output logic clk_render
);

    initial clk_render = 1'b0;

    always #(PERIOD / 2.0) clk_render = ~clk_render;

endmodule

// File: design/runner_core.sv
`timescale 1ns/100ps

module runner_core #(
    parameter int DEBOUNCE_CYCLES = 416000, // 5 ms at 12 ns
    parameter int LAG_SCALE       = 65536,
    parameter int DIGIT_CYCLES    = 1024
) (
    input  logic                       clk_render,
    input  logic                       rst,
    input  logic [3:0]                 btn,         // left, duck, jump, right
    input  logic [7:0]                 frame_lag,
    input  logic                       obstacle_valid,
    input  runner_pkg::lane_t          obstacle_lane,
    input  runner_pkg::obstacle_kind_t obstacle_kind,
    input  runner_pkg::depth_t         obstacle_depth,
    output logic                       frame_tick,
    output logic                       game_over,
    output runner_pkg::lane_t          player_lane,
    output runner_pkg::height_t        player_height,
    output runner_pkg::score_t         player_score,
    output logic                       ducking,
    output logic [7:0]                 seg_an,
    output logic [6:0]                 seg_cat
);

    controls_if ctl ();
    player_if   plyr ();

    button_conditioner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) u_buttons (
        .clk_render(clk_render),
        .rst       (rst),
        .btn       (btn),
        .ctl       (ctl.source)
    );

    frame_sequencer #(
        .LAG_SCALE(LAG_SCALE)
    ) u_sequencer (
        .clk_render(clk_render),
        .rst       (rst),
        .frame_lag (frame_lag),
        .ctl       (ctl.frame_source)
    );

    player_physics u_player (
        .clk_render    (clk_render),
        .rst           (rst),
        .ctl           (ctl.sink),
        .obstacle_valid(obstacle_valid),
        .obstacle_lane (obstacle_lane),
        .obstacle_kind (obstacle_kind),
        .obstacle_depth(obstacle_depth),
        .plyr          (plyr.source)
    );

    hex_display_scanner #(
        .DIGIT_CYCLES(DIGIT_CYCLES)
    ) u_display (
        .clk_render(clk_render),
        .rst       (rst),
        .plyr      (plyr.display),
        .seg_an    (seg_an),
        .seg_cat   (seg_cat)
    );

    assign frame_tick    = ctl.frame_tick;
    assign game_over     = plyr.game_over;
    assign player_lane   = plyr.lane;
    assign player_height = plyr.height;
    assign player_score  = plyr.score;
    assign ducking       = plyr.ducking;

endmodule

// File: design/hex_display_scanner.sv
`timescale 1ns/100ps

module hex_display_scanner #(
    parameter int DIGIT_CYCLES = 1024   // cycles each digit stays lit
) (
    input  logic        clk_render,
    input  logic        rst,
    player_if.display   plyr,
    output logic [7:0]  seg_an,         // active low, one digit at a time
    output logic [6:0]  seg_cat         // active low, bit 0 = a .. bit 6 = g
);

    localparam int DIV_W = $clog2(DIGIT_CYCLES + 1);

    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       digit;    // active digit index
    logic [31:0]      shown;    // score in the top half, height below
    logic [3:0]       nibble;
    logic [6:0]       segs;     // active high pattern

    always_ff @(posedge clk_render) begin
        if (rst) begin
            div_cnt <= '0;
            digit   <= 3'd0;
            shown   <= '0;
        end else if (div_cnt == DIV_W'(DIGIT_CYCLES - 1)) begin
            div_cnt <= '0;
            digit   <= digit + 3'd1;
            if (digit == 3'd7) begin
                shown <= {plyr.score, plyr.height};   // snapshot per full scan
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign nibble = shown[{digit, 2'b00} +: 4];

    // hex font, gfedcba
    always_comb begin
        case (nibble)
            4'h0: segs = 7'h3f;
            4'h1: segs = 7'h06;
            4'h2: segs = 7'h5b;
            4'h3: segs = 7'h4f;
            4'h4: segs = 7'h66;
            4'h5: segs = 7'h6d;
            4'h6: segs = 7'h7d;
            4'h7: segs = 7'h07;
            4'h8: segs = 7'h7f;
            4'h9: segs = 7'h6f;
            4'ha: segs = 7'h77;
            4'hb: segs = 7'h7c;   // lower case b
            4'hc: segs = 7'h39;
            4'hd: segs = 7'h5e;   // lower case d
            4'he: segs = 7'h79;
            default: segs = 7'h71;
        endcase
    end

    assign seg_cat = ~segs;
    assign seg_an  = ~(8'd1 << digit);

endmodule

// File: design/player_physics.sv
`timescale 1ns/100ps

module player_physics (
    input  logic                       clk_render,
    input  logic                       rst,
    controls_if.sink                   ctl,
    input  logic                       obstacle_valid,
    input  runner_pkg::lane_t          obstacle_lane,
    input  runner_pkg::obstacle_kind_t obstacle_kind,
    input  runner_pkg::depth_t         obstacle_depth,
    player_if.source                   plyr
);
    import runner_pkg::*;

    lane_t      lane;
    height_t    height;
    height_t    velocity;   // positive is up
    score_t     score;
    logic [7:0] duck_cnt;   // frames of duck left
    logic       game_over;
    logic       ducking;

    height_t    vel_next;
    height_t    height_next;
    logic       in_reach;   // obstacle level with the player
    logic       hit;

    assign ducking = (duck_cnt != 8'd0);

    // jumps only take off from the floor
    always_comb begin
        vel_next    = (ctl.jump && height == GROUND) ? VERTICAL_JUMP : velocity;
        height_next = height + vel_next;
    end

    // collision test runs every cycle an obstacle is presented
    always_comb begin
        in_reach = obstacle_valid && (obstacle_lane == lane) && (obstacle_depth < HIT_DEPTH);
        case (obstacle_kind)
            KIND_LOW_BARRIER:  hit = in_reach && !(height > GROUND + LOW_CLEARANCE);
            KIND_HIGH_BARRIER: hit = in_reach && !ducking;
            KIND_WALL:         hit = in_reach;
            default:           hit = in_reach;     // unknown kind counts as solid
        endcase
    end

    always_ff @(posedge clk_render) begin
        if (rst) begin
            game_over <= 1'b0;
        end else if (hit) begin
            game_over <= 1'b1;     // sticky
        end
    end

    // per-frame update, frozen once the game is over
    always_ff @(posedge clk_render) begin
        if (rst) begin
            lane     <= LANE_START;
            height   <= GROUND;
            velocity <= '0;
            score    <= '0;
            duck_cnt <= '0;
        end else if (ctl.frame_tick && !game_over) begin
            // lane change, left wins if both arrive together
            if (ctl.left && lane != 2'd0) begin
                lane <= lane - 2'd1;
            end else if (ctl.right && lane != 2'd2) begin
                lane <= lane + 2'd1;
            end

            if (height_next < GROUND) begin
                height   <= GROUND;     // landed
                velocity <= '0;
            end else begin
                height   <= height_next;
                velocity <= vel_next - GRAVITY;
            end

            if (ctl.duck) begin
                duck_cnt <= DUCK_LIMIT;             // a new duck restarts the timer
            end else if (duck_cnt != 8'd0) begin
                duck_cnt <= duck_cnt - 8'd1;
            end

            score <= score + SPEED;
        end
    end

    assign plyr.lane      = lane;
    assign plyr.height    = height;
    assign plyr.score     = score;
    assign plyr.ducking   = ducking;
    assign plyr.game_over = game_over;

endmodule

// File: design/frame_sequencer.sv
`timescale 1ns/100ps

module frame_sequencer #(
    parameter int LAG_SCALE = 65536     // cycles per frame_lag step
) (
    input  logic             clk_render,
    input  logic             rst,
    input  logic [7:0]       frame_lag,
    controls_if.frame_source ctl
);
    import runner_pkg::*;

    seq_state_t  state;
    logic        tick;
    logic [6:0]  settle_cnt;
    logic [31:0] lag_cnt;       // cycles since the last ST_START
    logic [31:0] lag_target;    // minimum frame length in cycles

    // frame = 1 start cycle + SETTLE_CYCLES + at least 1 lag cycle
    always_ff @(posedge clk_render) begin
        if (rst) begin
            state      <= ST_RESET;
            tick       <= 1'b0;
            settle_cnt <= '0;
            lag_cnt    <= '0;
            lag_target <= '0;
        end else begin
            tick    <= 1'b0;
            lag_cnt <= lag_cnt + 32'd1;

            if (tick) begin
                lag_target <= 32'(frame_lag) * 32'(LAG_SCALE);  // new lag per frame
            end

            case (state)
                ST_RESET: state <= ST_START;
                ST_START: begin
                    tick       <= 1'b1;
                    settle_cnt <= '0;
                    lag_cnt    <= 32'd1;    // counts from this cycle
                    state      <= ST_SETTLE;
                end
                ST_SETTLE: begin
                    if (settle_cnt == SETTLE_CYCLES - 7'd1) begin
                        state <= ST_LAG;
                    end else begin
                        settle_cnt <= settle_cnt + 7'd1;
                    end
                end
                ST_LAG: begin
                    // next cycle would complete the requested length
                    if (lag_cnt + 32'd1 >= lag_target) begin
                        state <= ST_START;
                    end
                end
                default: state <= ST_RESET;
            endcase
        end
    end

    assign ctl.frame_tick = tick;

endmodule

// File: design/button_conditioner.sv
`timescale 1ns/100ps

module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 416000  // cycles a new level must hold
) (
    input  logic       clk_render,
    input  logic       rst,
    input  logic [3:0] btn,         // left, duck, jump, right
    controls_if.source ctl
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [CNT_W-1:0] db_cnt [4];   // one counter per button
    logic [3:0]       clean;        // debounced levels
    logic [3:0]       clean_prev;   // levels at the previous tick
    logic [3:0]       edges;        // rising edges, updated per frame

    // a level is accepted once the raw input disagrees with it
    // for DEBOUNCE_CYCLES cycles in a row
    always_ff @(posedge clk_render) begin
        if (rst) begin
            clean <= '0;
            for (int i = 0; i < 4; i++) begin
                db_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (btn[i] == clean[i]) begin
                    db_cnt[i] <= '0;                // bounce, start over
                end else if (db_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    clean[i]  <= btn[i];            // held long enough
                    db_cnt[i] <= '0;
                end else begin
                    db_cnt[i] <= db_cnt[i] + 1'b1;
                end
            end
        end
    end

    // edge capture once per frame
    // a button held across ticks gives a single edge
    always_ff @(posedge clk_render) begin
        if (rst) begin
            clean_prev <= '0;
            edges      <= '0;
        end else if (ctl.frame_tick) begin
            clean_prev <= clean;
            edges      <= clean & ~clean_prev;
        end
    end

    assign ctl.left  = edges[3];
    assign ctl.duck  = edges[2];
    assign ctl.jump  = edges[1];
    assign ctl.right = edges[0];

endmodule

// File: design/runner_ifs.sv
`timescale 1ns/100ps

// player controls, one rising edge per button, plus the frame tick
interface controls_if;
    logic left;         // rising edges seen up to the last tick
    logic right;
    logic jump;
    logic duck;
    logic frame_tick;   // one cycle per frame

    // button side, edges are registered on the tick
    modport source (
        output left, right, jump, duck,
        input  frame_tick
    );

    modport frame_source (
        output frame_tick
    );

    // game logic reads everything
    modport sink (
        input left, right, jump, duck, frame_tick
    );
endinterface

// player state as seen by the display and the top level
interface player_if;
    import runner_pkg::*;

    lane_t   lane;
    height_t height;
    score_t  score;
    logic    ducking;
    logic    game_over;    // sticky until reset

    modport source (
        output lane, height, score, ducking, game_over
    );

    // display only needs the numbers
    modport display (
        input score, height
    );
endinterface

// File: design/runner_pkg.sv
package runner_pkg;

    // field types shared by the game core
    typedef logic [1:0]         lane_t;      // lanes 0..2, left to right
    typedef logic signed [15:0] height_t;    // vertical position and velocity
    typedef logic [15:0]        score_t;     // distance travelled
    typedef logic [10:0]        depth_t;     // obstacle distance ahead of the player

    // obstacle kinds as carried on the obstacle stream
    typedef enum logic [1:0] {
        KIND_LOW_BARRIER  = 2'd0,   // jump over it
        KIND_HIGH_BARRIER = 2'd1,   // duck under it
        KIND_WALL         = 2'd2    // no way past
    } obstacle_kind_t;

    // frame sequencer states
    typedef enum logic [1:0] {
        ST_RESET  = 2'd0,
        ST_START  = 2'd1,   // issues the frame tick
        ST_SETTLE = 2'd2,   // fixed settle time after each tick
        ST_LAG    = 2'd3    // stretches the frame to the selected lag
    } seq_state_t;

    // vertical motion, all in 128ths of a block
    localparam height_t GROUND        = -16'sd128;  // floor level
    localparam height_t GRAVITY       = 16'sd1;     // velocity lost per frame
    localparam height_t VERTICAL_JUMP = 16'sd190;   // launch velocity
    localparam height_t LOW_CLEARANCE = 16'sd15;    // margin over a low barrier

    // frames a duck is held for
    localparam logic [7:0] DUCK_LIMIT = 8'd128;

    localparam score_t SPEED = 16'd1;               // score per live frame

    // obstacles closer than this are level with the player
    localparam depth_t HIT_DEPTH = 11'd64;

    localparam logic [6:0] SETTLE_CYCLES = 7'd100;  // cycles in ST_SETTLE

    localparam lane_t LANE_START = 2'd1;            // middle lane

endpackage
